// File: design/pe_geom_pkg.sv
`default_nettype none

package pe_geom_pkg;

    // signed weight and feature values
    localparam int VALUE_W = 8;

    // row and column coordinates, offsets wrap at this width
    localparam int COORD_W = 8;

    // full-width signed product of two values
    localparam int PROD_W = 2 * VALUE_W;

endpackage

`default_nettype wire

// File: design/pe_ctrl_pkg.sv
`default_nettype none

package pe_ctrl_pkg;

    // feature beats per weight group
    localparam int BEAT_W = 16;

    // control states
    localparam logic ST_LOAD   = 1'b0;
    localparam logic ST_STREAM = 1'b1;

endpackage

`default_nettype wire

// File: design/pe_control.sv
`default_nettype none

module pe_control
    import pe_ctrl_pkg::*;
#(
    parameter int LANES = 4
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              weight_valid,
    input  wire logic                              feature_valid,
    input  wire logic [BEAT_W-1:0]                 feature_beats,
    output logic                                   weight_ready,
    output logic                                   feature_ready,
    output logic                                   weight_we,
    output logic [((LANES > 1) ? $clog2(LANES) : 1)-1:0] weight_slot,
    output logic                                   feature_we,
    output logic                                   out_valid
);

    localparam int SLOT_W = (LANES > 1) ? $clog2(LANES) : 1;
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(LANES - 1);

    logic              state;
    logic [SLOT_W-1:0] slot_cnt;
    logic [BEAT_W-1:0] beat_cnt;
    logic [BEAT_W-1:0] beat_limit;
    logic [BEAT_W-1:0] beat_next;
    logic              last_slot;
    logic              last_beat;

    assign weight_ready  = (state == ST_LOAD);
    assign feature_ready = (state == ST_STREAM);

    // strobes fire only on accepted beats
    assign weight_we  = weight_valid && weight_ready;
    assign feature_we = feature_valid && feature_ready;

    assign weight_slot = slot_cnt;
    assign last_slot   = (slot_cnt == LAST_SLOT);
    assign beat_next   = beat_cnt + 1'b1;
    assign last_beat   = (beat_next == beat_limit);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_LOAD;
            slot_cnt   <= '0;
            beat_cnt   <= '0;
            beat_limit <= '0;
            out_valid  <= 1'b0;
        end else begin
            // results come out one cycle after acceptance
            out_valid <= feature_we;
            case (state)
                ST_LOAD: begin
                    if (weight_we) begin
                        if (last_slot) begin
                            state      <= ST_STREAM;
                            slot_cnt   <= '0;
                            beat_cnt   <= '0;
                            beat_limit <= feature_beats;
                        end else begin
                            slot_cnt <= slot_cnt + 1'b1;
                        end
                    end
                end
                ST_STREAM: begin
                    if (feature_we) begin
                        if (last_beat) begin
                            // last beat of the group returns to weight loading
                            state    <= ST_LOAD;
                            beat_cnt <= '0;
                        end else begin
                            beat_cnt <= beat_next;
                        end
                    end
                end
                default: state <= ST_LOAD;
            endcase
        end
    end

    // a zero-beat group would never leave the stream state
    a_beats_nonzero: assert property (
        @(posedge clk) disable iff (rst)
        (weight_we && last_slot) |-> (feature_beats != '0)
    ) else $error("feature_beats is zero when the weight group completes");

    // streamed beats stay below the latched group size
    a_beat_in_range: assert property (
        @(posedge clk) disable iff (rst)
        (state == ST_STREAM) |-> (beat_cnt < beat_limit)
    ) else $error("beat count %0d reached the group size %0d", beat_cnt, beat_limit);

endmodule

`default_nettype wire

// File: design/weight_bank.sv
`default_nettype none

module weight_bank
    import pe_geom_pkg::*;
#(
    parameter int LANES = 4
) (
    input  wire logic                                         clk,
    input  wire logic                                         rst,
    input  wire logic                                         weight_we,
    input  wire logic [((LANES > 1) ? $clog2(LANES) : 1)-1:0] weight_slot,
    input  wire logic [VALUE_W-1:0]                           weight_value,
    input  wire logic [COORD_W-1:0]                           weight_row,
    input  wire logic [COORD_W-1:0]                           weight_col,
    output logic [LANES*VALUE_W-1:0]                          bank_values,
    output logic [LANES*COORD_W-1:0]                          bank_rows,
    output logic [LANES*COORD_W-1:0]                          bank_cols
);

    // one entry per slot, slot 0 in the low bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank_values <= '0;
            bank_rows   <= '0;
            bank_cols   <= '0;
        end else if (weight_we) begin
            bank_values[weight_slot*VALUE_W +: VALUE_W] <= weight_value;
            bank_rows[weight_slot*COORD_W +: COORD_W]   <= weight_row;
            bank_cols[weight_slot*COORD_W +: COORD_W]   <= weight_col;
        end
    end

    // slot counter must stay inside the bank
    a_slot_range: assert property (
        @(posedge clk) disable iff (rst)
        weight_we |-> (weight_slot < LANES)
    ) else $error("weight write to slot %0d outside the bank", weight_slot);

endmodule

`default_nettype wire

// File: design/pe_mult_array.sv
`default_nettype none

module pe_mult_array
    import pe_geom_pkg::*;
#(
    parameter int LANES = 4
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              feature_we,
    input  wire logic [LANES*VALUE_W-1:0]          bank_values,
    input  wire logic [LANES*VALUE_W-1:0]          feature_values,
    output logic [LANES*LANES*PROD_W-1:0]          products
);

    logic signed [PROD_W-1:0] weight_ext  [LANES];
    logic signed [PROD_W-1:0] feature_ext [LANES];

    // sign-extend both operands to product width
    for (genvar i = 0; i < LANES; i++) begin : g_ext
        assign weight_ext[i]  = $signed(bank_values[i*VALUE_W +: VALUE_W]);
        assign feature_ext[i] = $signed(feature_values[i*VALUE_W +: VALUE_W]);
    end

    // entry index is slot * LANES + lane
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            products <= '0;
        end else if (feature_we) begin
            for (int w = 0; w < LANES; w++) begin
                for (int f = 0; f < LANES; f++) begin
                    products[(w*LANES + f)*PROD_W +: PROD_W] <=
                        weight_ext[w] * feature_ext[f];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/coord_offset.sv
`default_nettype none

module coord_offset
    import pe_geom_pkg::*;
#(
    parameter int LANES = 4
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              feature_we,
    input  wire logic [LANES*COORD_W-1:0]          bank_rows,
    input  wire logic [LANES*COORD_W-1:0]          bank_cols,
    input  wire logic [LANES*COORD_W-1:0]          feature_rows,
    input  wire logic [LANES*COORD_W-1:0]          feature_cols,
    output logic [LANES*LANES*COORD_W-1:0]         offset_rows,
    output logic [LANES*LANES*COORD_W-1:0]         offset_cols
);

    logic [COORD_W-1:0] row_diff [LANES*LANES];
    logic [COORD_W-1:0] col_diff [LANES*LANES];

    // feature minus weight, wraps naturally at COORD_W
    for (genvar w = 0; w < LANES; w++) begin : g_slot
        for (genvar f = 0; f < LANES; f++) begin : g_lane
            assign row_diff[w*LANES + f] = feature_rows[f*COORD_W +: COORD_W]
                                         - bank_rows[w*COORD_W +: COORD_W];
            assign col_diff[w*LANES + f] = feature_cols[f*COORD_W +: COORD_W]
                                         - bank_cols[w*COORD_W +: COORD_W];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            offset_rows <= '0;
            offset_cols <= '0;
        end else if (feature_we) begin
            for (int i = 0; i < LANES*LANES; i++) begin
                offset_rows[i*COORD_W +: COORD_W] <= row_diff[i];
                offset_cols[i*COORD_W +: COORD_W] <= col_diff[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/pe_top.sv
`default_nettype none

module pe_top
    import pe_geom_pkg::*;
    import pe_ctrl_pkg::*;
#(
    parameter int LANES = 4
) (
    input  wire logic                              clk,
    input  wire logic                              rst,

    // weight channel, one sparse weight per beat
    input  wire logic                              weight_valid,
    output logic                                   weight_ready,
    input  wire logic [VALUE_W-1:0]                weight_value,
    input  wire logic [COORD_W-1:0]                weight_row,
    input  wire logic [COORD_W-1:0]                weight_col,

    input  wire logic [BEAT_W-1:0]                 feature_beats,

    // feature channel, LANES sparse features per beat
    input  wire logic                              feature_valid,
    output logic                                   feature_ready,
    input  wire logic [LANES*VALUE_W-1:0]          feature_values,
    input  wire logic [LANES*COORD_W-1:0]          feature_rows,
    input  wire logic [LANES*COORD_W-1:0]          feature_cols,

    // results, no back-pressure
    output logic                                   out_valid,
    output logic [LANES*LANES*PROD_W-1:0]          products,
    output logic [LANES*LANES*COORD_W-1:0]         offset_rows,
    output logic [LANES*LANES*COORD_W-1:0]         offset_cols
);

    localparam int SLOT_W = (LANES > 1) ? $clog2(LANES) : 1;

    logic                       weight_we;
    logic [SLOT_W-1:0]          weight_slot;
    logic                       feature_we;
    logic [LANES*VALUE_W-1:0]   bank_values;
    logic [LANES*COORD_W-1:0]   bank_rows;
    logic [LANES*COORD_W-1:0]   bank_cols;

    pe_control #(.LANES(LANES)) pe_control_inst (
        .clk           (clk),
        .rst           (rst),
        .weight_valid  (weight_valid),
        .feature_valid (feature_valid),
        .feature_beats (feature_beats),
        .weight_ready  (weight_ready),
        .feature_ready (feature_ready),
        .weight_we     (weight_we),
        .weight_slot   (weight_slot),
        .feature_we    (feature_we),
        .out_valid     (out_valid)
    );

    weight_bank #(.LANES(LANES)) weight_bank_inst (
        .clk          (clk),
        .rst          (rst),
        .weight_we    (weight_we),
        .weight_slot  (weight_slot),
        .weight_value (weight_value),
        .weight_row   (weight_row),
        .weight_col   (weight_col),
        .bank_values  (bank_values),
        .bank_rows    (bank_rows),
        .bank_cols    (bank_cols)
    );

    pe_mult_array #(.LANES(LANES)) pe_mult_array_inst (
        .clk            (clk),
        .rst            (rst),
        .feature_we     (feature_we),
        .bank_values    (bank_values),
        .feature_values (feature_values),
        .products       (products)
    );

    coord_offset #(.LANES(LANES)) coord_offset_inst (
        .clk          (clk),
        .rst          (rst),
        .feature_we   (feature_we),
        .bank_rows    (bank_rows),
        .bank_cols    (bank_cols),
        .feature_rows (feature_rows),
        .feature_cols (feature_cols),
        .offset_rows  (offset_rows),
        .offset_cols  (offset_cols)
    );

endmodule

`default_nettype wire

// File: tb/pe_tb_tasks.svh
`ifndef PE_TB_TASKS_SVH
`define PE_TB_TASKS_SVH

// reference model, signed weight times signed feature
function automatic integer expected_product(input integer weight, input integer feature);
    return weight * feature;
endfunction

// feature coordinate minus weight coordinate, wrapped
function automatic logic [COORD_W-1:0] expected_offset(input integer feature_coord,
                                                       input integer weight_coord);
    integer diff;
    diff = feature_coord - weight_coord;
    return diff[COORD_W-1:0];
endfunction

task automatic wait_weight_ready();
    integer cycles;
    cycles = 0;
    while (weight_ready !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
        @(posedge clk);
        #1;
        cycles++;
    end
    if (weight_ready !== 1'b1) begin
        $display("timeout: weight_ready stayed low for %0d cycles in test %s",
                 TIMEOUT_CYCLES, test_name);
        timeout_count++;
        aborted = 1'b1;
    end
endtask

task automatic wait_feature_ready();
    integer cycles;
    cycles = 0;
    while (feature_ready !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
        @(posedge clk);
        #1;
        cycles++;
    end
    if (feature_ready !== 1'b1) begin
        $display("timeout: feature_ready stayed low for %0d cycles in test %s",
                 TIMEOUT_CYCLES, test_name);
        timeout_count++;
        aborted = 1'b1;
    end
endtask

task automatic load_weight(input integer value, input integer row, input integer col);
    if (aborted) return;
    weight_value = value[VALUE_W-1:0];
    weight_row = row[COORD_W-1:0];
    weight_col = col[COORD_W-1:0];
    weight_valid = 1'b1;
    // junk feature beat while the bank loads, must be ignored
    feature_values = $random(seed);
    feature_rows = $random(seed);
    feature_cols = $random(seed);
    feature_valid = 1'b1;
    wait_weight_ready();
    if (aborted) return;
    @(posedge clk);
    #1;
    weight_valid = 1'b0;
    feature_valid = 1'b0;
endtask

task automatic send_feature();
    if (aborted) return;
    for (int i = 0; i < LANES; i++) begin
        feature_values[i*VALUE_W +: VALUE_W] = fv[i][VALUE_W-1:0];
        feature_rows[i*COORD_W +: COORD_W] = fr[i][COORD_W-1:0];
        feature_cols[i*COORD_W +: COORD_W] = fc[i][COORD_W-1:0];
    end
    feature_valid = 1'b1;
    wait_feature_ready();
    if (aborted) return;
    @(posedge clk);
    #1;
    feature_valid = 1'b0;
endtask

`endif

// File: tb/pe_top_tb.sv
`default_nettype none

module pe_top_tb
    import pe_geom_pkg::*;
    import pe_ctrl_pkg::*;
();

    localparam int LANES = 4;
    localparam int TIMEOUT_CYCLES = 100;

    logic                          clk;
    logic                          rst;
    logic                          weight_valid;
    logic                          weight_ready;
    logic [VALUE_W-1:0]            weight_value;
    logic [COORD_W-1:0]            weight_row;
    logic [COORD_W-1:0]            weight_col;
    logic [BEAT_W-1:0]             feature_beats;
    logic                          feature_valid;
    logic                          feature_ready;
    logic [LANES*VALUE_W-1:0]      feature_values;
    logic [LANES*COORD_W-1:0]      feature_rows;
    logic [LANES*COORD_W-1:0]      feature_cols;
    logic                          out_valid;
    logic [LANES*LANES*PROD_W-1:0] products;
    logic [LANES*LANES*COORD_W-1:0] offset_rows;
    logic [LANES*LANES*COORD_W-1:0] offset_cols;

    integer seed;
    integer error_count;
    integer timeout_count;
    integer beats_checked;
    bit     aborted;

    // current test, weights of the loaded group and the beat in flight
    string  test_name;
    integer test_beats;
    integer max_gap;
    integer slots_loaded;
    integer beats_done;
    integer wv [LANES];
    integer wr [LANES];
    integer wc [LANES];
    integer fv [LANES];
    integer fr [LANES];
    integer fc [LANES];
    integer exp_sum;

    `include "pe_tb_tasks.svh"

    pe_top #(.LANES(LANES)) pe_top_inst (
        .clk            (clk),
        .rst            (rst),
        .weight_valid   (weight_valid),
        .weight_ready   (weight_ready),
        .weight_value   (weight_value),
        .weight_row     (weight_row),
        .weight_col     (weight_col),
        .feature_beats  (feature_beats),
        .feature_valid  (feature_valid),
        .feature_ready  (feature_ready),
        .feature_values (feature_values),
        .feature_rows   (feature_rows),
        .feature_cols   (feature_cols),
        .out_valid      (out_valid),
        .products       (products),
        .offset_rows    (offset_rows),
        .offset_cols    (offset_cols)
    );

    always #4 clk = ~clk;

    task automatic report_mismatch(input string what, input integer expected,
                                   input integer actual);
        $display("ERROR test=%s %s expected=%0d actual=%0d", test_name, what, expected, actual);
        error_count++;
    endtask

    // sampled one cycle after the acceptance edge
    task automatic check_results();
        integer idx;
        integer exp_p;
        integer act_p;
        integer dut_sum;
        logic signed [PROD_W-1:0] prod_word;
        logic [COORD_W-1:0] exp_o;
        logic [COORD_W-1:0] act_o;
        dut_sum = 0;
        if (out_valid !== 1'b1) begin
            report_mismatch("out_valid after accepted beat", 1, out_valid);
        end
        for (int w = 0; w < LANES; w++) begin
            for (int f = 0; f < LANES; f++) begin
                idx = w*LANES + f;
                prod_word = products[idx*PROD_W +: PROD_W];
                act_p = prod_word;
                exp_p = expected_product(wv[w], fv[f]);
                if (act_p != exp_p) begin
                    report_mismatch($sformatf("product[%0d]", idx), exp_p, act_p);
                end
                dut_sum += act_p;
                exp_o = expected_offset(fr[f], wr[w]);
                act_o = offset_rows[idx*COORD_W +: COORD_W];
                if (act_o !== exp_o) begin
                    report_mismatch($sformatf("offset_row[%0d]", idx), exp_o, act_o);
                end
                exp_o = expected_offset(fc[f], wc[w]);
                act_o = offset_cols[idx*COORD_W +: COORD_W];
                if (act_o !== exp_o) begin
                    report_mismatch($sformatf("offset_col[%0d]", idx), exp_o, act_o);
                end
            end
        end
        if (dut_sum != exp_sum) begin
            report_mismatch("sum of products", exp_sum, dut_sum);
        end
        beats_checked++;
    endtask

    task automatic run_line(input logic [8*256-1:0] text_line);
        string  tag;
        string  name;
        integer n;
        integer a;
        integer b;
        integer c;
        integer gap;
        n = $sscanf(text_line, "%s", tag);
        if (n < 1 || tag.getc(0) == "#") return;
        if (tag == "test") begin
            n = $sscanf(text_line, "%s %s %d %d", tag, name, a, b);
            if (n != 4) begin
                $display("malformed test line in the data file");
                error_count++;
                return;
            end
            test_name = name;
            test_beats = a;
            max_gap = b;
            slots_loaded = 0;
            beats_done = 0;
            feature_beats = a[BEAT_W-1:0];
        end else if (tag == "w") begin
            n = $sscanf(text_line, "%s %d %d %d", tag, a, b, c);
            if (n != 4 || slots_loaded >= LANES) begin
                $display("unexpected weight line in test %s", test_name);
                error_count++;
                return;
            end
            wv[slots_loaded] = a;
            wr[slots_loaded] = b;
            wc[slots_loaded] = c;
            load_weight(a, b, c);
            if (aborted) return;
            if (out_valid !== 1'b0) begin
                report_mismatch("out_valid during weight load", 0, out_valid);
            end
            slots_loaded++;
            if (slots_loaded == LANES) begin
                if (weight_ready !== 1'b0) begin
                    report_mismatch("weight_ready after last weight", 0, weight_ready);
                end
                if (feature_ready !== 1'b1) begin
                    report_mismatch("feature_ready after last weight", 1, feature_ready);
                end
            end
        end else if (tag == "f") begin
            n = $sscanf(text_line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d", tag,
                        fv[0], fr[0], fc[0], fv[1], fr[1], fc[1],
                        fv[2], fr[2], fc[2], fv[3], fr[3], fc[3], exp_sum);
            if (n != 14 || slots_loaded != LANES) begin
                $display("unexpected feature line in test %s", test_name);
                error_count++;
                return;
            end
            send_feature();
            if (aborted) return;
            check_results();
            beats_done++;
            if (beats_done == test_beats) begin
                if (feature_ready !== 1'b0) begin
                    report_mismatch("feature_ready after last beat", 0, feature_ready);
                end
                if (weight_ready !== 1'b1) begin
                    report_mismatch("weight_ready after last beat", 1, weight_ready);
                end
            end else begin
                gap = (max_gap > 0) ? {$random(seed)} % (max_gap + 1) : 0;
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                    if (out_valid !== 1'b0) begin
                        report_mismatch("out_valid in idle cycle", 0, out_valid);
                    end
                end
            end
        end else begin
            $display("unknown line type %s in the data file", tag);
            error_count++;
        end
    endtask

    initial begin
        integer fd;
        integer r;
        logic [8*256-1:0] text_line;
        clk = 1'b0;
        rst = 1'b1;
        weight_valid = 1'b0;
        weight_value = '0;
        weight_row = '0;
        weight_col = '0;
        feature_beats = '0;
        feature_valid = 1'b0;
        feature_values = '0;
        feature_rows = '0;
        feature_cols = '0;
        seed = 32350;
        error_count = 0;
        timeout_count = 0;
        beats_checked = 0;
        aborted = 1'b0;
        test_name = "reset";
        slots_loaded = 0;
        beats_done = 0;

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        if (weight_ready !== 1'b1) report_mismatch("weight_ready after reset", 1, weight_ready);
        if (feature_ready !== 1'b0) report_mismatch("feature_ready after reset", 0, feature_ready);
        if (out_valid !== 1'b0) report_mismatch("out_valid after reset", 0, out_valid);

        fd = $fopen("tb/pe_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file tb/pe_tests.txt");
            error_count++;
        end else begin
            while (!$feof(fd) && !aborted) begin
                text_line = '0;
                r = $fgets(text_line, fd);
                if (r > 0) run_line(text_line);
            end
            $fclose(fd);
        end
        if (beats_checked == 0) begin
            $display("no feature beats were checked");
            error_count++;
        end

        $display("summary: %0d errors, %0d timeouts, %0d beats checked",
                 error_count, timeout_count, beats_checked);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/pe_tests.txt
# test <name> <beats> <max idle gap>, then w <value> <row> <col> once per weight slot
# f then <value> <row> <col> for each of the four lanes, then the expected sum of 16 products
test basic 3 0
w 1 2 3
w -2 4 5
w 3 0 0
w 4 10 10
f 1 1 1 2 2 2 -3 3 3 5 4 4 30
f 10 20 30 -10 0 0 7 255 1 0 9 9 42
f -1 5 6 -1 5 6 -1 5 6 -1 5 6 -24
test extremes 4 3
w -128 0 0
w 127 255 255
w -1 128 1
w 0 7 200
f -128 0 0 127 1 1 -128 2 2 127 3 3 4
f -128 255 255 -128 0 255 -128 255 0 -128 128 128 1024
f 127 9 9 127 9 9 127 9 9 127 9 9 -1016
f 0 1 2 0 3 4 1 5 6 -1 7 8 0
test regroup 5 2
w 5 1 1
w -6 2 2
w 9 3 3
w 2 4 4
f 1 0 0 1 0 0 1 0 0 1 0 0 40
f 2 6 6 -3 7 7 4 8 8 -5 9 9 -20
f 100 50 60 -100 70 80 50 90 100 -50 110 120 0
f 12 3 3 13 4 4 14 5 5 15 6 6 540
f -7 1 1 -8 2 2 -9 3 3 -10 4 4 -340

// File: flist.f
+incdir+tb
design/pe_geom_pkg.sv
design/pe_ctrl_pkg.sv
design/pe_control.sv
design/weight_bank.sv
design/pe_mult_array.sv
design/coord_offset.sv
design/pe_top.sv
tb/pe_top_tb.sv

// File: Bender.yml
package:
  name: sparse_conv_pe

sources:
  - design/pe_geom_pkg.sv
  - design/pe_ctrl_pkg.sv
  - design/pe_control.sv
  - design/weight_bank.sv
  - design/pe_mult_array.sv
  - design/coord_offset.sv
  - design/pe_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/pe_top_tb.sv
